// ==== rtl/serial_link_pkg.sv ====
//////////////////////////////
// Serial link shared types
// Flit layout, credit type and link widths
//////////////////////////////

package serial_link_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int PayloadWidth = 32;
  localparam int CreditWidth  = 4;
  localparam int FlitWidth    = 40;

  // Default receive buffer depth, also the initial transmit credit count
  localparam int NumCreditsDefault = 8;

  typedef logic [CreditWidth-1:0]  credit_t;
  typedef logic [PayloadWidth-1:0] payload_t;

  //////////////////////////////
  // Flit formats
  //////////////////////////////

  // Framed view used in normal mode
  typedef struct packed {
    payload_t   payload;
    credit_t    credits;
    logic       credit_only;
    logic [2:0] spare;
  } link_frame_t;

  // One PHY word, framed in normal mode and raw in calibration mode
  typedef union packed {
    link_frame_t          frame;
    logic [FlitWidth-1:0] raw;
  } link_flit_u;

endpackage

// ==== rtl/serial_link_credit_ctrl.sv ====
//////////////////////////////
// Serial link credit control
// Transmit credits and credits owed to the far side
//////////////////////////////

`timescale 1ns/1ps

module serial_link_credit_ctrl #(
  parameter int NumCredits      = serial_link_pkg::NumCreditsDefault,
  parameter int ForceSendThresh = NumCredits - 2
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     data_sent_i,
  input  logic                     credit_sent_i,
  input  logic                     rx_credit_valid_i,
  input  serial_link_pkg::credit_t rx_credits_i,
  input  logic                     payload_popped_i,
  output logic                     tx_credit_ok_o,
  output logic                     force_credit_req_o,
  output serial_link_pkg::credit_t credits_to_send_o
);
  import serial_link_pkg::*;

  // Cycles without a data flit before the link counts as idle
  localparam logic [1:0] IdleLimit = 2'd3;

  credit_t    tx_credits_q, tx_credits_d;
  credit_t    pending_q, pending_d;
  credit_t    fresh_q, fresh_d;
  credit_t    owed_total;
  logic [1:0] idle_cnt_q;
  logic       link_idle;

  always_comb begin
    tx_credits_d = tx_credits_q;
    if (data_sent_i) begin
      tx_credits_d = tx_credits_d - credit_t'(1);
    end
    if (rx_credit_valid_i) begin
      tx_credits_d = tx_credits_d + rx_credits_i;
    end
  end

  // Pending count only moves when a flit leaves, so the credit field of an
  // offered flit holds still under PHY back-pressure
  always_comb begin
    if (data_sent_i || credit_sent_i) begin
      pending_d = fresh_q + credit_t'(payload_popped_i);
      fresh_d   = '0;
    end else begin
      pending_d = pending_q;
      fresh_d   = fresh_q + credit_t'(payload_popped_i);
    end
  end

  assign owed_total = pending_q + fresh_q;
  assign link_idle  = (idle_cnt_q == IdleLimit);

  assign tx_credit_ok_o     = (tx_credits_q != '0);
  assign credits_to_send_o  = pending_q;
  assign force_credit_req_o = (owed_total >= credit_t'(ForceSendThresh)) ||
                              ((owed_total != '0) && link_idle);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_credits_q <= credit_t'(NumCredits);
      pending_q    <= '0;
      fresh_q      <= '0;
      idle_cnt_q   <= '0;
    end else begin
      tx_credits_q <= tx_credits_d;
      pending_q    <= pending_d;
      fresh_q      <= fresh_d;
      if (data_sent_i) begin
        idle_cnt_q <= '0;
      end else if (!link_idle) begin
        idle_cnt_q <= idle_cnt_q + 2'd1;
      end
    end
  end

endmodule

// ==== rtl/serial_link_rx_path.sv ====
//////////////////////////////
// Serial link receive path
// Unpacks flits, drops credit-only flits, buffers payloads
//////////////////////////////

`timescale 1ns/1ps

module serial_link_rx_path #(
  parameter int NumCredits = serial_link_pkg::NumCreditsDefault
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  serial_link_pkg::link_flit_u phy_data_i,
  input  logic                        phy_valid_i,
  output logic                        phy_ready_o,
  input  logic                        raw_mode_en_i,
  output serial_link_pkg::payload_t   m_payload_o,
  output logic                        m_valid_o,
  input  logic                        m_ready_i,
  output serial_link_pkg::link_flit_u raw_in_data_o,
  output logic                        raw_in_valid_o,
  input  logic                        raw_in_ready_i,
  output logic                        rx_credit_valid_o,
  output serial_link_pkg::credit_t    rx_credits_o,
  output logic                        payload_popped_o
);
  import serial_link_pkg::*;

  localparam int PtrWidth = (NumCredits > 1) ? $clog2(NumCredits) : 1;

  payload_t            buf_mem [NumCredits];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  credit_t             count_q;
  link_frame_t         frame;
  logic                buf_full;
  logic                flit_accept;
  logic                push;
  logic                pop;

  assign frame    = phy_data_i.frame;
  assign buf_full = (count_q == credit_t'(NumCredits));

  // Credit-only flits are always taken, data waits for buffer space
  assign phy_ready_o = raw_mode_en_i ? raw_in_ready_i : (frame.credit_only || !buf_full);

  assign flit_accept = phy_valid_i && phy_ready_o && !raw_mode_en_i;
  assign push        = flit_accept && !frame.credit_only;
  assign pop         = m_valid_o && m_ready_i;

  assign rx_credit_valid_o = flit_accept && (frame.credits != '0);
  assign rx_credits_o      = frame.credits;
  assign payload_popped_o  = pop;

  // Raw view goes straight to the config read port
  assign raw_in_data_o.raw = raw_mode_en_i ? phy_data_i.raw : '0;
  assign raw_in_valid_o    = raw_mode_en_i && phy_valid_i;

  assign m_valid_o   = (count_q != '0);
  assign m_payload_o = buf_mem[rd_ptr_q];

  //////////////////////////////
  // Receive buffer
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(NumCredits - 1)) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(NumCredits - 1)) ? '0 : rd_ptr_q + PtrWidth'(1);
      end
      count_q <= count_q + credit_t'(push) - credit_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_mem[wr_ptr_q] <= frame.payload;
    end
  end

endmodule

// ==== rtl/serial_link_raw_fifo.sv ====
//////////////////////////////
// Serial link raw-mode FIFO
// Holds calibration words until the PHY takes them
//////////////////////////////

`timescale 1ns/1ps

module serial_link_raw_fifo #(
  parameter int Depth = 4
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  clear_i,
  input  logic [serial_link_pkg::FlitWidth-1:0] push_data_i,
  input  logic                                  push_valid_i,
  input  logic                                  pop_i,
  output logic [serial_link_pkg::FlitWidth-1:0] raw_word_o,
  output logic                                  raw_valid_o,
  output logic [$clog2(Depth+1)-1:0]            fill_o,
  output logic                                  full_o
);

  localparam int PtrWidth  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int FillWidth = $clog2(Depth + 1);

  logic [serial_link_pkg::FlitWidth-1:0] mem [Depth];
  logic [PtrWidth-1:0]                   wr_ptr_q, rd_ptr_q;
  logic [FillWidth-1:0]                  fill_q;
  logic                                  push, pop;

  // Writes into a full FIFO are lost
  assign push = push_valid_i && !full_o;
  assign pop  = pop_i && raw_valid_o;

  assign full_o      = (fill_q == FillWidth'(Depth));
  assign raw_valid_o = (fill_q != '0);
  assign fill_o      = fill_q;
  assign raw_word_o  = mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + PtrWidth'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + PtrWidth'(1);
      end
      fill_q <= fill_q + FillWidth'(push) - FillWidth'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== rtl/serial_link_phy_arbiter.sv ====
//////////////////////////////
// Serial link PHY arbiter
// Frames outgoing flits and picks data, credit-only or raw
//////////////////////////////

`timescale 1ns/1ps

module serial_link_phy_arbiter (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic                                  raw_mode_en_i,
  input  logic                                  raw_out_en_i,
  input  serial_link_pkg::payload_t             s_payload_i,
  input  logic                                  s_valid_i,
  output logic                                  s_ready_o,
  input  logic                                  tx_credit_ok_i,
  input  logic                                  force_credit_req_i,
  input  serial_link_pkg::credit_t              credits_to_send_i,
  input  logic [serial_link_pkg::FlitWidth-1:0] raw_word_i,
  input  logic                                  raw_valid_i,
  output logic                                  raw_pop_o,
  output logic                                  data_sent_o,
  output logic                                  credit_sent_o,
  output serial_link_pkg::link_flit_u           phy_data_o,
  output logic                                  phy_valid_o,
  input  logic                                  phy_ready_i
);
  import serial_link_pkg::*;

  logic        data_req, credit_req, raw_req;
  logic        gnt_data, gnt_credit, gnt_raw;
  logic        held_data_q, held_credit_q, held_raw_q;
  logic        lock_q;
  // Set when the credit-only source wins the next tie
  logic        rr_credit_q;
  link_frame_t frame;

  assign data_req   = !raw_mode_en_i && s_valid_i && tx_credit_ok_i;
  assign credit_req = !raw_mode_en_i && force_credit_req_i;
  assign raw_req    = raw_mode_en_i && raw_out_en_i && raw_valid_i;

  always_comb begin
    if (lock_q) begin
      // Keep the grant of a flit the PHY has not taken yet
      gnt_data   = held_data_q && data_req;
      gnt_credit = held_credit_q && credit_req;
      gnt_raw    = held_raw_q && raw_req;
    end else begin
      gnt_raw    = raw_req;
      gnt_data   = data_req && !(credit_req && rr_credit_q);
      gnt_credit = credit_req && !(data_req && !rr_credit_q);
    end
  end

  // Build the outgoing word
  always_comb begin
    frame.payload     = gnt_data ? s_payload_i : '0;
    frame.credits     = credits_to_send_i;
    frame.credit_only = gnt_credit;
    frame.spare       = '0;
    if (gnt_raw) begin
      phy_data_o.raw = raw_word_i;
    end else begin
      phy_data_o.frame = frame;
    end
  end

  assign phy_valid_o   = gnt_data || gnt_credit || gnt_raw;
  assign s_ready_o     = gnt_data && phy_ready_i;
  assign data_sent_o   = gnt_data && phy_ready_i;
  assign credit_sent_o = gnt_credit && phy_ready_i;
  assign raw_pop_o     = gnt_raw && phy_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q        <= 1'b0;
      held_data_q   <= 1'b0;
      held_credit_q <= 1'b0;
      held_raw_q    <= 1'b0;
      rr_credit_q   <= 1'b0;
    end else begin
      lock_q        <= phy_valid_o && !phy_ready_i;
      held_data_q   <= gnt_data;
      held_credit_q <= gnt_credit;
      held_raw_q    <= gnt_raw;
      if (data_sent_o) begin
        rr_credit_q <= 1'b1;
      end else if (credit_sent_o) begin
        rr_credit_q <= 1'b0;
      end
    end
  end

endmodule

// ==== rtl/serial_link_data_link.sv ====
//////////////////////////////
// Serial link data link layer
// Credit flow control and raw calibration mode over one PHY channel
//////////////////////////////

`timescale 1ns/1ps

module serial_link_data_link #(
  parameter int  NumCredits      = serial_link_pkg::NumCreditsDefault,
  parameter int  ForceSendThresh = NumCredits - 2,
  localparam int RawFifoDepth    = 4,
  localparam int RawFillWidth    = $clog2(RawFifoDepth + 1)
) (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  // Payload streams
  input  serial_link_pkg::payload_t             s_payload_i,
  input  logic                                  s_valid_i,
  output logic                                  s_ready_o,
  output serial_link_pkg::payload_t             m_payload_o,
  output logic                                  m_valid_o,
  input  logic                                  m_ready_i,
  // PHY channel
  output serial_link_pkg::link_flit_u           phy_data_o,
  output logic                                  phy_valid_o,
  input  logic                                  phy_ready_i,
  input  serial_link_pkg::link_flit_u           phy_data_i,
  input  logic                                  phy_valid_i,
  output logic                                  phy_ready_o,
  // Calibration config
  input  logic                                  cfg_raw_mode_en_i,
  input  logic                                  cfg_raw_out_en_i,
  input  logic [serial_link_pkg::FlitWidth-1:0] cfg_raw_out_data_i,
  input  logic                                  cfg_raw_out_valid_i,
  input  logic                                  cfg_raw_fifo_clear_i,
  input  logic                                  cfg_raw_in_ready_i,
  output logic [serial_link_pkg::FlitWidth-1:0] cfg_raw_in_data_o,
  output logic                                  cfg_raw_in_valid_o,
  output logic [RawFillWidth-1:0]               cfg_raw_fifo_fill_o,
  output logic                                  cfg_raw_fifo_full_o
);
  import serial_link_pkg::*;

  logic                 tx_credit_ok;
  logic                 force_credit_req;
  credit_t              credits_to_send;
  logic                 data_sent;
  logic                 credit_sent;
  logic                 rx_credit_valid;
  credit_t              rx_credits;
  logic                 payload_popped;
  logic [FlitWidth-1:0] raw_word;
  logic                 raw_valid;
  logic                 raw_pop;
  link_flit_u           raw_in_flit;

  assign cfg_raw_in_data_o = raw_in_flit.raw;

  //////////////////////////////
  // Flow control
  //////////////////////////////

  serial_link_credit_ctrl #(
    .NumCredits      ( NumCredits      ),
    .ForceSendThresh ( ForceSendThresh )
  ) i_credit_ctrl (
    .clk_i              ( clk_i            ),
    .rst_n_i            ( rst_n_i          ),
    .data_sent_i        ( data_sent        ),
    .credit_sent_i      ( credit_sent      ),
    .rx_credit_valid_i  ( rx_credit_valid  ),
    .rx_credits_i       ( rx_credits       ),
    .payload_popped_i   ( payload_popped   ),
    .tx_credit_ok_o     ( tx_credit_ok     ),
    .force_credit_req_o ( force_credit_req ),
    .credits_to_send_o  ( credits_to_send  )
  );

  //////////////////////////////
  // Receive side
  //////////////////////////////

  serial_link_rx_path #(
    .NumCredits ( NumCredits )
  ) i_rx_path (
    .clk_i             ( clk_i              ),
    .rst_n_i           ( rst_n_i            ),
    .phy_data_i        ( phy_data_i         ),
    .phy_valid_i       ( phy_valid_i        ),
    .phy_ready_o       ( phy_ready_o        ),
    .raw_mode_en_i     ( cfg_raw_mode_en_i  ),
    .m_payload_o       ( m_payload_o        ),
    .m_valid_o         ( m_valid_o          ),
    .m_ready_i         ( m_ready_i          ),
    .raw_in_data_o     ( raw_in_flit        ),
    .raw_in_valid_o    ( cfg_raw_in_valid_o ),
    .raw_in_ready_i    ( cfg_raw_in_ready_i ),
    .rx_credit_valid_o ( rx_credit_valid    ),
    .rx_credits_o      ( rx_credits         ),
    .payload_popped_o  ( payload_popped     )
  );

  //////////////////////////////
  // Transmit side
  //////////////////////////////

  serial_link_raw_fifo #(
    .Depth ( RawFifoDepth )
  ) i_raw_fifo (
    .clk_i        ( clk_i                ),
    .rst_n_i      ( rst_n_i              ),
    .clear_i      ( cfg_raw_fifo_clear_i ),
    .push_data_i  ( cfg_raw_out_data_i   ),
    .push_valid_i ( cfg_raw_out_valid_i  ),
    .pop_i        ( raw_pop              ),
    .raw_word_o   ( raw_word             ),
    .raw_valid_o  ( raw_valid            ),
    .fill_o       ( cfg_raw_fifo_fill_o  ),
    .full_o       ( cfg_raw_fifo_full_o  )
  );

  serial_link_phy_arbiter i_phy_arbiter (
    .clk_i              ( clk_i             ),
    .rst_n_i            ( rst_n_i           ),
    .raw_mode_en_i      ( cfg_raw_mode_en_i ),
    .raw_out_en_i       ( cfg_raw_out_en_i  ),
    .s_payload_i        ( s_payload_i       ),
    .s_valid_i          ( s_valid_i         ),
    .s_ready_o          ( s_ready_o         ),
    .tx_credit_ok_i     ( tx_credit_ok      ),
    .force_credit_req_i ( force_credit_req  ),
    .credits_to_send_i  ( credits_to_send   ),
    .raw_word_i         ( raw_word          ),
    .raw_valid_i        ( raw_valid         ),
    .raw_pop_o          ( raw_pop           ),
    .data_sent_o        ( data_sent         ),
    .credit_sent_o      ( credit_sent       ),
    .phy_data_o         ( phy_data_o        ),
    .phy_valid_o        ( phy_valid_o       ),
    .phy_ready_i        ( phy_ready_i       )
  );

endmodule

// ==== dv/tb_serial_link_data_link.sv ====
//////////////////////////////
// Serial link data link testbench
// PHY loopback driven from a trace file
//////////////////////////////

`timescale 1ns/1ps

module tb_serial_link_data_link;
  import serial_link_pkg::*;

  localparam int num_credits = 8;
  localparam int raw_depth   = 4;

  logic clk, rst_n;
  payload_t s_payload, m_payload;
  logic s_valid, s_ready, m_valid, m_ready;
  link_flit_u phy_data_out, phy_data_in;
  logic phy_valid_out, phy_ready_in, phy_valid_in, phy_ready_out;
  logic raw_mode, raw_out_en, raw_out_valid, raw_clear, raw_in_ready, raw_in_valid, raw_full;
  logic [FlitWidth-1:0] raw_out_data, raw_in_data;
  logic [2:0] raw_fill;

  // One-deep loopback channel and sampled handshakes
  link_flit_u chan_data, out_word;
  logic chan_valid, out_fire, in_fire, s_fire, m_hold, m_rand, link_busy;
  payload_t tx_q[$];
  payload_t rx_q[$];
  link_flit_u raw_tx_q[$];
  link_flit_u raw_rx_q[$];
  logic [FlitWidth-1:0] raw_words[$];
  int err_cnt, check_cnt, test_cnt, sent_idx;

  serial_link_data_link #(.NumCredits(num_credits)) dut (
    .clk_i(clk), .rst_n_i(rst_n),
    .s_payload_i(s_payload), .s_valid_i(s_valid), .s_ready_o(s_ready),
    .m_payload_o(m_payload), .m_valid_o(m_valid), .m_ready_i(m_ready),
    .phy_data_o(phy_data_out), .phy_valid_o(phy_valid_out), .phy_ready_i(phy_ready_in),
    .phy_data_i(phy_data_in), .phy_valid_i(phy_valid_in), .phy_ready_o(phy_ready_out),
    .cfg_raw_mode_en_i(raw_mode), .cfg_raw_out_en_i(raw_out_en),
    .cfg_raw_out_data_i(raw_out_data), .cfg_raw_out_valid_i(raw_out_valid),
    .cfg_raw_fifo_clear_i(raw_clear), .cfg_raw_in_ready_i(raw_in_ready),
    .cfg_raw_in_data_o(raw_in_data), .cfg_raw_in_valid_o(raw_in_valid),
    .cfg_raw_fifo_fill_o(raw_fill), .cfg_raw_fifo_full_o(raw_full)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////
  // Loopback channel and monitors
  //////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      chan_valid = 1'b0;
    end else begin
      if (in_fire) chan_valid = 1'b0;
      if (out_fire) begin
        chan_data  = out_word;
        chan_valid = 1'b1;
      end
    end
    phy_valid_in = chan_valid;
    phy_data_in  = chan_data;
    phy_ready_in = !chan_valid && (($urandom % 4) != 0);
    m_ready      = m_hold ? 1'b0 : (m_rand ? 1'($urandom % 2) : 1'b1);
    // Sample once the falling-edge inputs have settled
    #1;
    out_fire  = phy_valid_out && phy_ready_in;
    out_word  = phy_data_out;
    in_fire   = phy_valid_in && phy_ready_out;
    s_fire    = s_valid && s_ready;
    link_busy = phy_valid_out || chan_valid || m_valid;
    if (out_fire && raw_mode) raw_tx_q.push_back(phy_data_out);
    if (m_valid && m_ready) rx_q.push_back(m_payload);
    if (raw_in_valid && raw_in_ready) raw_rx_q.push_back(link_flit_u'(raw_in_data));
  end

  task automatic check_payload(input string name, input payload_t got, input payload_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_credit(input string name, input credit_t got, input credit_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flit(input string name, input link_flit_u got, input link_flit_u exp);
    check_cnt++;
    if (got.raw !== exp.raw) begin
      err_cnt++;
      $display("error at %0t: %s got %h expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // Offers tx_q in order, stops when done or after max_idle cycles without a transfer
  task automatic send_payloads(input int max_idle);
    int idle;
    idle = 0;
    while (sent_idx < tx_q.size() && idle < max_idle) begin
      s_valid   = 1'b1;
      s_payload = tx_q[sent_idx];
      @(negedge clk);
      if (s_fire) begin
        sent_idx++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    s_valid = 1'b0;
  endtask

  task automatic wait_outputs(input int n);
    int guard;
    guard = 0;
    while (rx_q.size() < n && guard < 5000) begin
      @(negedge clk);
      guard++;
    end
    if (rx_q.size() < n) begin
      err_cnt++;
      $display("timeout waiting for %0d payloads, only %0d arrived", n, rx_q.size());
    end
  endtask

  task automatic drain_link();
    int guard, quiet;
    guard = 0;
    quiet = 0;
    while (quiet < 8 && guard < 3000) begin
      @(negedge clk);
      guard++;
      quiet = link_busy ? 0 : quiet + 1;
    end
    if (quiet < 8) begin
      err_cnt++;
      $display("timeout waiting for the link to go quiet");
    end
  endtask

  task automatic write_raw_words();
    raw_clear = 1'b1;
    @(negedge clk);
    raw_clear = 1'b0;
    foreach (raw_words[i]) begin
      raw_out_valid = 1'b1;
      raw_out_data  = raw_words[i];
      @(negedge clk);
    end
    raw_out_valid = 1'b0;
  endtask

  task automatic check_raw_queue(input string name, input int n);
    int guard;
    link_flit_u exp;
    guard = 0;
    while ((name == "phy_data_o" ? raw_tx_q.size() : raw_rx_q.size()) < n && guard < 2000) begin
      @(negedge clk);
      guard++;
    end
    for (int i = 0; i < n; i++) begin
      exp.raw = raw_words[i];
      if (name == "phy_data_o" && i < raw_tx_q.size()) check_flit(name, raw_tx_q[i], exp);
      else if (name != "phy_data_o" && i < raw_rx_q.size()) check_flit(name, raw_rx_q[i], exp);
      else begin
        err_cnt++;
        $display("raw word %0d never arrived on %s", i, name);
      end
    end
  endtask

  task automatic run_test(input int id, input int exp_cnt);
    int errs_before;
    errs_before = err_cnt;
    sent_idx    = 0;
    rx_q.delete();
    raw_tx_q.delete();
    raw_rx_q.delete();
    case (id)
      1, 3: begin
        m_rand = (id == 3);
        send_payloads(3000);
        wait_outputs(tx_q.size());
        check_payload("payload count", payload_t'(rx_q.size()), payload_t'(tx_q.size()));
      end
      2: begin
        m_hold = 1'b1;
        send_payloads(40);
        check_credit("accepted before stall", credit_t'(sent_idx), credit_t'(exp_cnt));
        m_hold = 1'b0;
        send_payloads(3000);
        wait_outputs(tx_q.size());
      end
      4, 5: begin
        drain_link();
        raw_mode   = 1'b1;
        raw_out_en = (id == 5);
        write_raw_words();
        if (id == 4) begin
          check_credit("cfg_raw_fifo_fill_o", credit_t'(raw_fill), credit_t'(exp_cnt));
          check_credit("cfg_raw_fifo_full_o", credit_t'(raw_full),
                       credit_t'(exp_cnt == raw_depth));
          raw_out_en = 1'b1;
          check_raw_queue("phy_data_o", exp_cnt);
        end else begin
          check_raw_queue("cfg_raw_in_data_o", exp_cnt);
        end
        drain_link();
        raw_mode   = 1'b0;
        raw_out_en = 1'b0;
      end
      default: begin
        apply_reset();
        for (int i = 0; i < 5; i++) begin
          @(negedge clk);
          check_credit("s_ready_o", credit_t'(s_ready), '0);
          check_credit("m_valid_o", credit_t'(m_valid), '0);
          check_credit("phy_valid_o", credit_t'(phy_valid_out), '0);
        end
      end
    endcase
    for (int i = 0; i < tx_q.size() && i < rx_q.size(); i++) begin
      check_payload("m_payload_o", rx_q[i], tx_q[i]);
    end
    drain_link();
    m_rand = 1'b0;
    test_cnt++;
    $display("test %0d finished with %0d errors", id, err_cnt - errs_before);
  endtask

  initial begin
    int fd, n, test_id, exp_cnt;
    string line;
    byte tag;
    logic [63:0] val;
    void'($urandom(32'h7fba_1764));
    {s_payload, s_valid, raw_mode, raw_out_en, raw_out_valid, raw_out_data} = '0;
    {raw_clear, m_hold, m_rand, out_fire, in_fire, s_fire, chan_valid, link_busy} = '0;
    raw_in_ready = 1'b1;
    m_ready      = 1'b1;
    phy_ready_in = 1'b0;
    phy_valid_in = 1'b0;
    phy_data_in  = '0;
    chan_data    = '0;
    {err_cnt, check_cnt, test_cnt, test_id, exp_cnt} = '0;
    apply_reset();
    fd = $fopen("dv/serial_link_trace.txt", "r");
    if (fd == 0) begin
      err_cnt++;
      $display("cannot open the trace file");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && $sscanf(line, "%c %h", tag, val) == 2) begin
          case (tag)
            "T": test_id = int'(val);
            "P": tx_q.push_back(payload_t'(val));
            "N": for (int i = 0; i < int'(val); i++) tx_q.push_back($urandom);
            "R": raw_words.push_back(val[FlitWidth-1:0]);
            "E": exp_cnt = int'(val);
            "X": begin
              run_test(test_id, exp_cnt);
              tx_q.delete();
              raw_words.delete();
            end
            default: ;
          endcase
        end
      end
      $fclose(fd);
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== dv/serial_link_trace.txt ====
# Columns: tag value (hex). T test id, P payload, N random payload count,
# R raw word, E expected count, X run the test
T 6
X 0
T 1
P 01234567
P 89abcdef
P deadbeef
P 00000000
P ffffffff
P 5a5aa5a5
X 0
T 2
P 10000001
P 20000002
P 30000003
P 40000004
P 50000005
P 60000006
P 70000007
P 80000008
P 90000009
P a000000a
P b000000b
E 8
X 0
T 3
N 30
X 0
T 4
R 11aabbccdd
R 2233445566
R 33778899aa
R 44bbccddee
R 55ff001122
E 4
X 0
T 5
R a1a2a3a4a5
R b1b2b3b4b5
R c1c2c3c4c5
E 3
X 0

// ==== build.f ====
rtl/serial_link_pkg.sv
rtl/serial_link_credit_ctrl.sv
rtl/serial_link_rx_path.sv
rtl/serial_link_raw_fifo.sv
rtl/serial_link_phy_arbiter.sv
rtl/serial_link_data_link.sv
dv/tb_serial_link_data_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the serial link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_serial_link_data_link \
  -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
